// ==== rtl/rs_pkg.sv ====
package rs_pkg;

    typedef logic [7:0]  tag_t;    // physical register tag
    typedef logic [31:0] word_t;
    typedef logic [31:0] pc_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [2:0]  funct3_t;

    // result buses in priority order: alu, mul, div, load
    localparam int NUM_CDB   = 4;
    localparam int CDB_SEL_W = $clog2(NUM_CDB);

    typedef logic [CDB_SEL_W-1:0] cdb_sel_t;

    typedef struct packed {
        pc_t     pc;
        tag_t    rd;
        logic    mem_to_reg;
        logic    mem_read;
        logic    mem_write;
        alu_op_t alu_op;
        logic    alu_src1;
        logic    alu_src2;
        logic    jump;
        logic    branch;
        funct3_t funct3;
        word_t   imm;
    } rs_payload_t;

    typedef struct packed {
        rs_payload_t payload;
        tag_t        src1_tag;
        tag_t        src2_tag;
        word_t       src1_data;
        word_t       src2_data;
        logic        src1_valid;
        logic        src2_valid;
    } rs_dispatch_t;

    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t data;
    } rs_cdb_t;

    typedef struct packed {
        rs_payload_t payload;
        word_t       op1;
        word_t       op2;
    } rs_issue_t;

    // one dispatch source after bypass
    typedef struct packed {
        logic  valid;
        word_t data;
    } rs_src_t;

    typedef struct packed {
        logic     hit;
        cdb_sel_t sel;
    } cdb_match_t;

endpackage

// ==== rtl/rs_alloc_ctrl.sv ====
`timescale 1ns/1ps

module rs_alloc_ctrl #(
    parameter int RS_DEPTH = 8
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic [RS_DEPTH-1:0] issue_onehot,
    output logic [RS_DEPTH-1:0] alloc_onehot,
    output logic                alloc_we,
    output logic [RS_DEPTH-1:0] occupied,
    output logic                full
);

    logic [RS_DEPTH-1:0] free_slots;
    logic [RS_DEPTH-1:0] alloc_mask;

    assign free_slots   = ~occupied;
    assign alloc_onehot = free_slots & (~free_slots + RS_DEPTH'(1)); // lowest free bit
    assign full         = &occupied;
    assign alloc_we     = start & ~full;
    assign alloc_mask   = alloc_we ? alloc_onehot : '0;

    // issue only frees occupied slots and alloc only takes free ones
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            occupied <= '0;
        end else begin
            occupied <= (occupied & ~issue_onehot) | alloc_mask;
        end
    end

    a_no_start_when_full: assert property (
        @(posedge clk) disable iff (reset) !(start && full)
    ) else $error("start while station full");

    // selection must only grant live entries
    a_issue_occupied: assert property (
        @(posedge clk) disable iff (reset) (issue_onehot & ~occupied) == '0
    ) else $error("issue grant on free entry");

endmodule

// ==== rtl/rs_wakeup.sv ====
`timescale 1ns/1ps

module rs_wakeup #(
    parameter int RS_DEPTH = 8
) (
    input  rs_pkg::rs_dispatch_t                    dispatch,
    input  rs_pkg::rs_cdb_t [rs_pkg::NUM_CDB-1:0]   cdb,
    input  rs_pkg::tag_t                            src1_tags [RS_DEPTH],
    input  rs_pkg::tag_t                            src2_tags [RS_DEPTH],
    input  logic [RS_DEPTH-1:0]                     op_valid1,
    input  logic [RS_DEPTH-1:0]                     op_valid2,
    output logic [RS_DEPTH-1:0]                     capture1,
    output logic [RS_DEPTH-1:0]                     capture2,
    output rs_pkg::cdb_sel_t                        capture1_bus [RS_DEPTH],
    output rs_pkg::cdb_sel_t                        capture2_bus [RS_DEPTH],
    output rs_pkg::rs_src_t                         disp_src1,
    output rs_pkg::rs_src_t                         disp_src2
);

    rs_pkg::cdb_match_t hit1 [RS_DEPTH];
    rs_pkg::cdb_match_t hit2 [RS_DEPTH];
    rs_pkg::cdb_match_t disp_hit1;
    rs_pkg::cdb_match_t disp_hit2;

    // scan high to low so the lowest bus index wins
    function automatic rs_pkg::cdb_match_t lookup(rs_pkg::tag_t tag);
        rs_pkg::cdb_match_t m;
        m = '0;
        for (int b = rs_pkg::NUM_CDB - 1; b >= 0; b--) begin
            if (cdb[b].valid && cdb[b].tag == tag) begin
                m.hit = 1'b1;
                m.sel = rs_pkg::cdb_sel_t'(b);
            end
        end
        return m;
    endfunction

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            hit1[i]         = lookup(src1_tags[i]);
            hit2[i]         = lookup(src2_tags[i]);
            capture1[i]     = hit1[i].hit & ~op_valid1[i]; // only waiting operands
            capture2[i]     = hit2[i].hit & ~op_valid2[i];
            capture1_bus[i] = hit1[i].sel;
            capture2_bus[i] = hit2[i].sel;
        end
    end

    // same-cycle bypass for the dispatching micro-op
    assign disp_hit1 = lookup(dispatch.src1_tag);
    assign disp_hit2 = lookup(dispatch.src2_tag);

    assign disp_src1.valid = dispatch.src1_valid | disp_hit1.hit;
    assign disp_src1.data  = dispatch.src1_valid ? dispatch.src1_data : cdb[disp_hit1.sel].data;
    assign disp_src2.valid = dispatch.src2_valid | disp_hit2.hit;
    assign disp_src2.data  = dispatch.src2_valid ? dispatch.src2_data : cdb[disp_hit2.sel].data;

endmodule

// ==== rtl/rs_entry_array.sv ====
`timescale 1ns/1ps

module rs_entry_array #(
    parameter int RS_DEPTH = 8
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic [RS_DEPTH-1:0]                     alloc_onehot,
    input  logic                                    alloc_we,
    input  rs_pkg::rs_dispatch_t                    dispatch,
    input  rs_pkg::rs_src_t                         disp_src1,
    input  rs_pkg::rs_src_t                         disp_src2,
    input  logic [RS_DEPTH-1:0]                     capture1,
    input  logic [RS_DEPTH-1:0]                     capture2,
    input  rs_pkg::cdb_sel_t                        capture1_bus [RS_DEPTH],
    input  rs_pkg::cdb_sel_t                        capture2_bus [RS_DEPTH],
    input  rs_pkg::rs_cdb_t [rs_pkg::NUM_CDB-1:0]   cdb,
    input  logic [RS_DEPTH-1:0]                     issue_onehot,
    output rs_pkg::tag_t                            src1_tags [RS_DEPTH],
    output rs_pkg::tag_t                            src2_tags [RS_DEPTH],
    output logic [RS_DEPTH-1:0]                     op_valid1,
    output logic [RS_DEPTH-1:0]                     op_valid2,
    output rs_pkg::rs_issue_t                       entries [RS_DEPTH]
);

    logic [RS_DEPTH-1:0] write_en;

    assign write_en = alloc_we ? alloc_onehot : '0;

    // entry payload, tags and operand data
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (write_en[i]) begin
                entries[i].payload <= dispatch.payload;
                entries[i].op1     <= disp_src1.data;
                entries[i].op2     <= disp_src2.data;
                src1_tags[i]       <= dispatch.src1_tag;
                src2_tags[i]       <= dispatch.src2_tag;
            end else begin
                if (capture1[i]) begin
                    entries[i].op1 <= cdb[capture1_bus[i]].data;
                end
                if (capture2[i]) begin
                    entries[i].op2 <= cdb[capture2_bus[i]].data;
                end
            end
        end
    end

    // operand valid bits
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            op_valid1 <= '0;
            op_valid2 <= '0;
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (write_en[i]) begin
                    op_valid1[i] <= disp_src1.valid;
                    op_valid2[i] <= disp_src2.valid;
                end else if (issue_onehot[i]) begin
                    op_valid1[i] <= 1'b0; // entry leaves
                    op_valid2[i] <= 1'b0;
                end else begin
                    op_valid1[i] <= op_valid1[i] | capture1[i];
                    op_valid2[i] <= op_valid2[i] | capture2[i];
                end
            end
        end
    end

endmodule

// ==== rtl/rs_select.sv ====
`timescale 1ns/1ps

module rs_select #(
    parameter int RS_DEPTH = 8
) (
    input  logic                clk,
    input  logic                reset,
    input  logic [RS_DEPTH-1:0] occupied,
    input  logic [RS_DEPTH-1:0] op_valid1,
    input  logic [RS_DEPTH-1:0] op_valid2,
    input  rs_pkg::rs_issue_t   entries [RS_DEPTH],
    output logic [RS_DEPTH-1:0] issue_onehot,
    output logic                issue_valid,
    output rs_pkg::rs_issue_t   issue
);

    localparam int IDX_W = $clog2(RS_DEPTH);

    logic [RS_DEPTH-1:0] ready;
    logic [IDX_W-1:0]    grant_idx;

    assign ready        = occupied & op_valid1 & op_valid2;
    assign issue_onehot = ready & (~ready + RS_DEPTH'(1)); // lowest ready index

    always_comb begin
        grant_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (ready[i]) begin
                grant_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= |ready;
        end
    end

    always_ff @(posedge clk) begin
        if (|ready) begin
            issue <= entries[grant_idx];
        end
    end

    // freed entry is the single one that gets registered
    a_grant_onehot: assert property (
        @(posedge clk) disable iff (reset)
            issue_onehot == ((|ready) ? (RS_DEPTH'(1) << grant_idx) : '0)
    ) else $error("grant vector does not match the issued entry");

endmodule

// ==== rtl/rs_alu.sv ====
`timescale 1ns/1ps

module rs_alu #(
    parameter int RS_DEPTH = 8
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    start,
    input  rs_pkg::rs_dispatch_t                    dispatch,
    input  rs_pkg::rs_cdb_t [rs_pkg::NUM_CDB-1:0]   cdb,
    output logic                                    issue_valid,
    output rs_pkg::rs_issue_t                       issue,
    output logic                                    full
);

    logic [RS_DEPTH-1:0] alloc_onehot;
    logic                alloc_we;
    logic [RS_DEPTH-1:0] occupied;
    logic [RS_DEPTH-1:0] issue_onehot;
    logic [RS_DEPTH-1:0] op_valid1;
    logic [RS_DEPTH-1:0] op_valid2;
    logic [RS_DEPTH-1:0] capture1;
    logic [RS_DEPTH-1:0] capture2;
    rs_pkg::cdb_sel_t    capture1_bus [RS_DEPTH];
    rs_pkg::cdb_sel_t    capture2_bus [RS_DEPTH];
    rs_pkg::tag_t        src1_tags [RS_DEPTH];
    rs_pkg::tag_t        src2_tags [RS_DEPTH];
    rs_pkg::rs_src_t     disp_src1;
    rs_pkg::rs_src_t     disp_src2;
    rs_pkg::rs_issue_t   entries [RS_DEPTH];

    rs_alloc_ctrl #(.RS_DEPTH(RS_DEPTH)) rs_alloc_ctrl_i (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .issue_onehot (issue_onehot),
        .alloc_onehot (alloc_onehot),
        .alloc_we     (alloc_we),
        .occupied     (occupied),
        .full         (full)
    );

    rs_wakeup #(.RS_DEPTH(RS_DEPTH)) rs_wakeup_i (
        .dispatch     (dispatch),
        .cdb          (cdb),
        .src1_tags    (src1_tags),
        .src2_tags    (src2_tags),
        .op_valid1    (op_valid1),
        .op_valid2    (op_valid2),
        .capture1     (capture1),
        .capture2     (capture2),
        .capture1_bus (capture1_bus),
        .capture2_bus (capture2_bus),
        .disp_src1    (disp_src1),
        .disp_src2    (disp_src2)
    );

    rs_entry_array #(.RS_DEPTH(RS_DEPTH)) rs_entry_array_i (
        .clk          (clk),
        .reset        (reset),
        .alloc_onehot (alloc_onehot),
        .alloc_we     (alloc_we),
        .dispatch     (dispatch),
        .disp_src1    (disp_src1),
        .disp_src2    (disp_src2),
        .capture1     (capture1),
        .capture2     (capture2),
        .capture1_bus (capture1_bus),
        .capture2_bus (capture2_bus),
        .cdb          (cdb),
        .issue_onehot (issue_onehot),
        .src1_tags    (src1_tags),
        .src2_tags    (src2_tags),
        .op_valid1    (op_valid1),
        .op_valid2    (op_valid2),
        .entries      (entries)
    );

    rs_select #(.RS_DEPTH(RS_DEPTH)) rs_select_i (
        .clk          (clk),
        .reset        (reset),
        .occupied     (occupied),
        .op_valid1    (op_valid1),
        .op_valid2    (op_valid2),
        .entries      (entries),
        .issue_onehot (issue_onehot),
        .issue_valid  (issue_valid),
        .issue        (issue)
    );

endmodule

// ==== dv/rs_alu_tb.sv ====
`timescale 1ns/1ps

module rs_alu_tb;

    logic                                  clk;
    logic                                  reset;
    logic                                  start;
    rs_pkg::rs_dispatch_t                  dispatch;
    rs_pkg::rs_cdb_t [rs_pkg::NUM_CDB-1:0] cdb;
    logic                                  issue_valid;
    rs_pkg::rs_issue_t                     issue;
    logic                                  full;

    int    errors;
    int    checks;
    int    tests_passed;
    int    tests_failed;
    int    test_errors;
    int    cycles;
    string test_name;

    typedef logic [$bits(rs_pkg::rs_issue_t)-1:0] check_t;

    rs_pkg::rs_issue_t expected_q [$];

    rs_alu #(.RS_DEPTH(8)) rs_alu_i (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .dispatch    (dispatch),
        .cdb         (cdb),
        .issue_valid (issue_valid),
        .issue       (issue),
        .full        (full)
    );

    always #50 clk = ~clk;

    // stop a hung run
    always @(posedge clk) begin
        cycles++;
        if (cycles >= 400) begin
            $display("timeout: run did not finish within %0d cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

    a_reset_quiet: assert property (@(posedge clk) reset |-> (!issue_valid && !full))
        else begin
            errors++;
            $display("issue_valid or full high during reset");
        end

    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic check_val(string what, check_t expected, check_t actual);
        checks++;
        assert (expected === actual)
            else begin
                errors++;
                $display("error %s %s expected %h actual %h", test_name, what, expected, actual);
            end
    endtask

    task automatic begin_test(string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        if (errors == test_errors) begin
            tests_passed++;
            $display("test %s: pass", test_name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", test_name, errors - test_errors);
        end
    endtask

    function automatic rs_pkg::rs_dispatch_t make_uop(rs_pkg::tag_t t1, logic v1,
                                                      rs_pkg::tag_t t2, logic v2);
        rs_pkg::rs_dispatch_t d;
        logic [95:0]          rnd;
        rnd          = {$urandom, $urandom, $urandom};
        d.payload    = rnd[$bits(rs_pkg::rs_payload_t)-1:0]; // random payload fields
        d.src1_tag   = t1;
        d.src2_tag   = t2;
        d.src1_data  = $urandom;
        d.src2_data  = $urandom;
        d.src1_valid = v1;
        d.src2_valid = v2;
        return d;
    endfunction

    function automatic rs_pkg::rs_issue_t expect_issue(rs_pkg::rs_dispatch_t d,
                                                       rs_pkg::word_t op1, rs_pkg::word_t op2);
        rs_pkg::rs_issue_t r;
        r.payload = d.payload;
        r.op1     = op1;
        r.op2     = op2;
        return r;
    endfunction

    task automatic send_uop(rs_pkg::rs_dispatch_t d);
        start    = 1'b1;
        dispatch = d;
        step();
        start    = 1'b0;
    endtask

    task automatic broadcast(int bus, rs_pkg::tag_t tag, rs_pkg::word_t data);
        cdb[bus].valid = 1'b1;
        cdb[bus].tag   = tag;
        cdb[bus].data  = data;
        step();
        cdb = '0;
    endtask

    task automatic fill_waiting(int count, rs_pkg::tag_t tag);
        rs_pkg::rs_dispatch_t d;
        for (int i = 0; i < count; i++) begin
            d = make_uop(tag, 1'b0, 8'h01, 1'b1);
            expected_q.push_back(expect_issue(d, '0, d.src2_data));
            send_uop(d);
        end
    endtask

    // issue order is the queue order; op1 comes from the broadcast
    task automatic drain_in_order(rs_pkg::word_t op1);
        rs_pkg::rs_issue_t exp;
        while (expected_q.size() > 0) begin
            exp     = expected_q.pop_front();
            exp.op1 = op1;
            check_val("issue_valid", check_t'(1), check_t'(issue_valid));
            check_val("issue", exp, issue);
            step();
        end
        check_val("issue_valid idle", check_t'(0), check_t'(issue_valid));
    endtask

    initial begin
        rs_pkg::rs_dispatch_t d;
        rs_pkg::word_t        data;
        void'($urandom(32'hab5d_107c));
        clk      = 1'b0;
        reset    = 1'b1;
        start    = 1'b0;
        dispatch = '0;
        cdb      = '0;
        repeat (8) @(posedge clk);
        #10;
        reset = 1'b0;

        begin_test("reset");
        step();
        check_val("issue_valid", check_t'(0), check_t'(issue_valid));
        check_val("full", check_t'(0), check_t'(full));
        end_test();

        begin_test("ready_at_dispatch");
        d = make_uop(8'h11, 1'b1, 8'h12, 1'b1);
        send_uop(d);
        step();
        check_val("issue_valid", check_t'(1), check_t'(issue_valid));
        check_val("issue", expect_issue(d, d.src1_data, d.src2_data), issue);
        step();
        end_test();

        begin_test("wakeup");
        d = make_uop(8'h21, 1'b0, 8'h22, 1'b1);
        send_uop(d);
        step();
        check_val("issue_valid early", check_t'(0), check_t'(issue_valid));
        data = $urandom;
        broadcast(1, 8'h21, data);
        check_val("issue_valid at bus edge", check_t'(0), check_t'(issue_valid));
        step();
        check_val("issue_valid", check_t'(1), check_t'(issue_valid));
        check_val("issue", expect_issue(d, data, d.src2_data), issue);
        step();
        end_test();

        begin_test("bypass_priority");
        d = make_uop(8'h31, 1'b1, 8'h32, 1'b0);
        data = $urandom;
        cdb[0] = '{valid: 1'b1, tag: 8'h32, data: data};
        cdb[3] = '{valid: 1'b1, tag: 8'h32, data: ~data};
        send_uop(d);
        cdb = '0;
        step();
        check_val("issue_valid", check_t'(1), check_t'(issue_valid));
        check_val("issue", expect_issue(d, d.src1_data, data), issue);
        step();
        end_test();

        begin_test("selection_order");
        fill_waiting(5, 8'h50);
        data = $urandom;
        broadcast(2, 8'h50, data);
        step();
        drain_in_order(data);
        end_test();

        begin_test("full");
        fill_waiting(8, 8'h60);
        check_val("full after 8", check_t'(1), check_t'(full));
        data = $urandom;
        broadcast(0, 8'h60, data);
        check_val("full at wake edge", check_t'(1), check_t'(full));
        step();
        check_val("full after first issue", check_t'(0), check_t'(full));
        drain_in_order(data);
        end_test();

        $display("tests passed %0d failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== rs_alu.f ====
rtl/rs_pkg.sv
rtl/rs_alloc_ctrl.sv
rtl/rs_wakeup.sv
rtl/rs_entry_array.sv
rtl/rs_select.sv
rtl/rs_alu.sv
dv/rs_alu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the reservation station testbench with Verilator
verilator --binary --assert -f rs_alu.f --top-module rs_alu_tb -o rs_alu_sim > build.log 2>&1 \
    && ./obj_dir/rs_alu_sim > sim.log 2>&1 \
    || { cat build.log; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "^No errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
